/* dma_pkg.sv */
// I/O DMA shared definitions
`default_nettype none

package dma_pkg;

   ////////////////////
   // Sizes
   ////////////////////
   localparam int NUM_CPUS        = 2;
   localparam int NUM_CH          = 4;
   localparam int ADDR_W          = 22;
   localparam int WORD_W          = 64;
   localparam int HALF_W          = 16;
   localparam int A_W             = 24;
   localparam int HALVES_PER_WORD = 4;

   // Monitor-mode channel opcodes
   localparam logic [9:0] OP_WRITE_CA  = 10'o0010;
   localparam logic [9:0] OP_WRITE_CL  = 10'o0011;
   localparam logic [6:0] OP_CHAN_READ = 7'o033;

   // Aj of ch10, index 0
   localparam int CH_SEL_BASE = 8;

   typedef logic [1:0] ch_idx_t;

   // One instruction word, two decodings
   typedef union packed {
      struct packed {
         logic [9:0] op;
         logic [5:0] fld;
      } wr;
      struct packed {
         logic [6:0] op;
         logic [2:0] i;
         logic [5:0] jk;    // Zero selects interrupt read
      } rd;
   } instr_u;

   typedef struct packed {
      instr_u         instr;
      logic           mon_mode;
      logic           vld;
      logic [A_W-1:0] aj;
      logic [A_W-1:0] ak;
   } cpu_req_t;

   typedef enum logic [1:0] {NONE, WR_CA, WR_CL, RD} cpu_op_e;

   typedef struct packed {
      cpu_op_e           kind;
      logic              is_int;
      ch_idx_t           ch;
      logic              chan_ok;
      logic [ADDR_W-1:0] val;
   } cpu_op_t;

   typedef struct packed {
      logic              req;
      logic              wr;
      logic [ADDR_W-1:0] addr;
      logic [WORD_W-1:0] data;
   } mem_req_t;

endpackage

`default_nettype wire

/* cpu_instr_decode.sv */
// CPU channel instruction decoder
`timescale 1ns/1ps
`default_nettype none

module cpu_instr_decode (
   input  wire                    clk,
   input  wire                    rst,
   input  wire dma_pkg::cpu_req_t i_cpu,
   output dma_pkg::cpu_op_t       o_op
);
   import dma_pkg::*;

   cpu_req_t       cpu_q;
   logic [A_W-1:0] ch_off;

   // Flop the CPU side for timing
   always_ff @(posedge clk)
   begin
      cpu_q <= i_cpu;
      if (rst)
         cpu_q.vld <= 1'b0;
   end

   always_comb
   begin
      ch_off    = cpu_q.aj - A_W'(CH_SEL_BASE);
      o_op      = '0;
      o_op.kind = NONE;
      o_op.ch   = ch_off[1:0];
      o_op.chan_ok = (ch_off < A_W'(NUM_CH));   // Aj below base wraps high
      o_op.val     = cpu_q.ak[ADDR_W-1:0];
      o_op.is_int  = (cpu_q.instr.rd.jk == 6'd0);
      if (cpu_q.vld && cpu_q.mon_mode)
      begin
         if (cpu_q.instr.wr.op == OP_WRITE_CA)
            o_op.kind = WR_CA;
         else if (cpu_q.instr.wr.op == OP_WRITE_CL)
            o_op.kind = WR_CL;
         else if (cpu_q.instr.rd.op == OP_CHAN_READ)
            o_op.kind = RD;
      end
   end

endmodule

`default_nettype wire

/* chan_regs.sv */
// Channel address and limit registers
`timescale 1ns/1ps
`default_nettype none

module chan_regs (
   input  wire                     clk,
   input  wire                     rst,
   input  wire dma_pkg::cpu_op_t   i_op [dma_pkg::NUM_CPUS],
   input  wire                     i_cpl,
   input  wire dma_pkg::ch_idx_t   i_cpl_ch,
   output logic [dma_pkg::NUM_CH-1:0] o_active,
   output logic [dma_pkg::ADDR_W-1:0] o_ca [dma_pkg::NUM_CH],
   output logic [dma_pkg::A_W-1:0]    o_cpu_ai [dma_pkg::NUM_CPUS]
);
   import dma_pkg::*;

   logic [ADDR_W-1:0] cl [NUM_CH];
   logic [ADDR_W-1:0] ca_inc;
   logic [NUM_CH-1:0] int_vec;
   logic [NUM_CH-1:0] int_set;
   logic [NUM_CH-1:0] int_clr;
   logic              cpl_hit;
   logic              cpl_done;
   logic              any_int;
   ch_idx_t           int_idx;
   cpu_op_t           op_sel;
   int                win;

   ////////////////////
   // CPU arbitration
   ////////////////////
   // Lowest numbered CPU wins, the rest are dropped
   always_comb
   begin
      win = 0;
      for (int c = NUM_CPUS - 1; c >= 0; c--)
         if (i_op[c].kind != NONE)
            win = c;
      op_sel = i_op[win];
   end

   // Lowest pending interrupt
   always_comb
   begin
      any_int = |int_vec;
      int_idx = '0;
      for (int i = NUM_CH - 1; i >= 0; i--)
         if (int_vec[i])
            int_idx = ch_idx_t'(i);
   end

   assign ca_inc   = o_ca[i_cpl_ch] + 1'b1;
   assign cpl_hit  = i_cpl && o_active[i_cpl_ch];
   assign cpl_done = cpl_hit && (ca_inc == cl[i_cpl_ch]);
   assign int_set  = cpl_done ? (NUM_CH'(1) << i_cpl_ch) : '0;
   assign int_clr  = (op_sel.kind == RD && op_sel.is_int && any_int) ?
                     (NUM_CH'(1) << int_idx) : '0;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         o_active <= '0;
         int_vec  <= '0;
         for (int i = 0; i < NUM_CH; i++)
         begin
            o_ca[i] <= '0;
            cl[i]   <= '0;
         end
      end
      else
      begin
         int_vec <= (int_vec & ~int_clr) | int_set;
         if (cpl_hit)
         begin
            o_ca[i_cpl_ch] <= ca_inc;
            if (cpl_done)
               o_active[i_cpl_ch] <= 1'b0;   // Limit reached
         end
         // CPU write lands after the increment
         if (op_sel.chan_ok && op_sel.kind == WR_CA)
         begin
            o_ca[op_sel.ch]     <= op_sel.val;
            o_active[op_sel.ch] <= (op_sel.val != cl[op_sel.ch]);
         end
         if (op_sel.chan_ok && op_sel.kind == WR_CL)
            cl[op_sel.ch] <= op_sel.val;
      end
   end

   ////////////////////
   // Read results
   ////////////////////
   always_ff @(posedge clk)
   begin
      for (int c = 0; c < NUM_CPUS; c++)
      begin
         if (rst)
            o_cpu_ai[c] <= '0;
         else if (c == win && i_op[c].kind == RD)
         begin
            if (i_op[c].is_int)
               o_cpu_ai[c] <= any_int ? A_W'(CH_SEL_BASE) + A_W'(int_idx) : '0;
            else if (i_op[c].chan_ok)
               o_cpu_ai[c] <= A_W'(o_ca[i_op[c].ch]);
            else
               o_cpu_ai[c] <= '0;   // No such channel
         end
      end
   end

endmodule

`default_nettype wire

/* chan_rx.sv */
// Input channel halfword packer
`timescale 1ns/1ps
`default_nettype none

module chan_rx (
   input  wire                         clk,
   input  wire                         rst,
   input  wire [dma_pkg::HALF_W-1:0]   i_data,
   input  wire                         i_vld,
   output logic                        o_rdy,
   input  wire                         i_rd,
   output logic                        o_full,
   output logic [dma_pkg::WORD_W-1:0]  o_word
);
   import dma_pkg::*;

   logic [$clog2(HALVES_PER_WORD)-1:0] cnt;
   logic                               take;

   assign o_rdy = !o_full;   // Stall while a word waits
   assign take  = i_vld && o_rdy;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         cnt    <= '0;
         o_full <= 1'b0;
      end
      else
      begin
         if (i_rd)
            o_full <= 1'b0;
         if (take)
         begin
            cnt <= cnt + 1'b1;
            if (cnt == HALVES_PER_WORD - 1)
               o_full <= 1'b1;
         end
      end
   end

   // First halfword ends up on top
   always_ff @(posedge clk)
      if (take)
         o_word <= {o_word[WORD_W-HALF_W-1:0], i_data};

endmodule

`default_nettype wire

/* chan_tx.sv */
// Output channel halfword serializer
`timescale 1ns/1ps
`default_nettype none

module chan_tx (
   input  wire                         clk,
   input  wire                         rst,
   input  wire                         i_wr,
   input  wire [dma_pkg::WORD_W-1:0]   i_word,
   output logic                        o_empty,
   output logic [dma_pkg::HALF_W-1:0]  o_data,
   output logic                        o_vld,
   input  wire                         i_rdy
);
   import dma_pkg::*;

   logic [WORD_W-1:0]                  shreg;
   logic [$clog2(HALVES_PER_WORD)-1:0] cnt;
   logic                               sent;

   assign o_vld  = !o_empty;
   assign o_data = shreg[WORD_W-1 -: HALF_W];   // MS halfword first
   assign sent   = o_vld && i_rdy;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         o_empty <= 1'b1;
         cnt     <= '0;
      end
      else if (i_wr)
      begin
         o_empty <= 1'b0;
         cnt     <= '0;
      end
      else if (sent)
      begin
         cnt <= cnt + 1'b1;
         if (cnt == HALVES_PER_WORD - 1)
            o_empty <= 1'b1;   // Last halfword gone
      end
   end

   always_ff @(posedge clk)
   begin
      if (i_wr)
         shreg <= i_word;
      else if (sent)
         shreg <= {shreg[WORD_W-HALF_W-1:0], HALF_W'(0)};
   end

endmodule

`default_nettype wire

/* rr_arbiter.sv */
// Round-robin channel arbiter
`timescale 1ns/1ps
`default_nettype none

module rr_arbiter (
   input  wire                         clk,
   input  wire                         rst,
   input  wire [dma_pkg::NUM_CH-1:0]   i_req,
   input  wire                         i_take,
   output logic                        o_any,
   output dma_pkg::ch_idx_t            o_grant
);
   import dma_pkg::*;

   ch_idx_t last;
   ch_idx_t idx;

   // Walk backwards so the nearest index after the last grant wins
   always_comb
   begin
      o_any   = |i_req;
      o_grant = '0;
      idx     = '0;
      for (int k = NUM_CH; k >= 1; k--)
      begin
         idx = last + ch_idx_t'(k);
         if (i_req[idx])
            o_grant = idx;
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst)
         last <= ch_idx_t'(NUM_CH - 1);   // First pick starts at 0
      else if (i_take)
         last <= o_grant;
   end

endmodule

`default_nettype wire

/* mem_engine.sv */
// Shared memory transfer engine
`timescale 1ns/1ps
`default_nettype none

module mem_engine (
   input  wire                         clk,
   input  wire                         rst,
   input  wire [dma_pkg::NUM_CH-1:0]   i_active,
   input  wire [dma_pkg::ADDR_W-1:0]   i_ca [dma_pkg::NUM_CH],
   input  wire [dma_pkg::NUM_CH-1:0]   i_rx_full,
   input  wire [dma_pkg::WORD_W-1:0]   i_rx_word [dma_pkg::NUM_CH],
   input  wire [dma_pkg::NUM_CH-1:0]   i_tx_empty,
   output logic [dma_pkg::NUM_CH-1:0]  o_rx_rd,
   output logic [dma_pkg::NUM_CH-1:0]  o_tx_wr,
   output logic [dma_pkg::WORD_W-1:0]  o_tx_word,
   output dma_pkg::mem_req_t           o_mem,
   input  wire                         i_mem_ack,
   input  wire [dma_pkg::WORD_W-1:0]   i_mem_rdata,
   output logic                        o_cpl,
   output dma_pkg::ch_idx_t            o_cpl_ch
);
   import dma_pkg::*;

   typedef enum logic [1:0] {IDLE, FETCH, FORWARD} state_e;

   state_e            state;
   ch_idx_t           gnt;
   ch_idx_t           arb_grant;
   logic [ADDR_W-1:0] addr;
   logic [WORD_W-1:0] data;
   logic [NUM_CH-1:0] req;
   logic              arb_any;
   logic              is_in;
   logic              take;

   // Rx full only on inputs, tx empty only on outputs
   assign req   = i_active & (i_rx_full | i_tx_empty);
   assign take  = (state == IDLE) && arb_any;
   assign is_in = !gnt[0];   // Even index is an input channel

   rr_arbiter u_arb (
      .clk     (clk),
      .rst     (rst),
      .i_req   (req),
      .i_take  (take),
      .o_any   (arb_any),
      .o_grant (arb_grant)
   );

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state <= IDLE;
         gnt   <= '0;
      end
      else
      begin
         case (state)
            IDLE:
               if (arb_any)
               begin
                  gnt   <= arb_grant;
                  state <= FETCH;
               end
            FETCH:
               if (is_in || i_mem_ack)
                  state <= FORWARD;
            FORWARD:
               if (o_cpl)
                  state <= IDLE;
            default:
               state <= IDLE;
         endcase
      end
   end

   // Payload, address from CA at grant time
   always_ff @(posedge clk)
   begin
      if (take)
         addr <= i_ca[arb_grant];
      if (state == FETCH && is_in)
         data <= i_rx_word[gnt];
      else if (state == FETCH && i_mem_ack)
         data <= i_mem_rdata;
   end

   always_comb
   begin
      o_rx_rd = '0;
      o_tx_wr = '0;
      if (state == FETCH && is_in)
         o_rx_rd[gnt] = 1'b1;
      if (state == FORWARD && !is_in)
         o_tx_wr[gnt] = 1'b1;
   end

   assign o_tx_word  = data;
   assign o_mem.req  = (state == FETCH && !is_in) || (state == FORWARD && is_in);
   assign o_mem.wr   = (state == FORWARD) && is_in;
   assign o_mem.addr = addr;
   assign o_mem.data = data;
   assign o_cpl      = (state == FORWARD) && (!is_in || i_mem_ack);
   assign o_cpl_ch   = gnt;

endmodule

`default_nettype wire

/* io_dma_top.sv */
// I/O DMA controller top level
`timescale 1ns/1ps
`default_nettype none

module io_dma_top (
   input  wire                         clk,
   input  wire                         rst,
   input  wire dma_pkg::cpu_req_t      i_cpu [dma_pkg::NUM_CPUS],
   output logic [dma_pkg::A_W-1:0]     o_cpu_ai [dma_pkg::NUM_CPUS],
   // Input channels 10, 12
   input  wire [dma_pkg::HALF_W-1:0]   i_in_data [dma_pkg::NUM_CH/2],
   input  wire [dma_pkg::NUM_CH/2-1:0] i_in_vld,
   output logic [dma_pkg::NUM_CH/2-1:0] o_in_rdy,
   // Output channels 11, 13
   output logic [dma_pkg::HALF_W-1:0]  o_out_data [dma_pkg::NUM_CH/2],
   output logic [dma_pkg::NUM_CH/2-1:0] o_out_vld,
   input  wire [dma_pkg::NUM_CH/2-1:0] i_out_rdy,
   output dma_pkg::mem_req_t           o_mem,
   input  wire                         i_mem_ack,
   input  wire [dma_pkg::WORD_W-1:0]   i_mem_rdata
);
   import dma_pkg::*;

   wire cpu_op_t           cpu_op [NUM_CPUS];
   wire [NUM_CH-1:0]       active;
   wire [ADDR_W-1:0]       ca [NUM_CH];
   wire [NUM_CH-1:0]       rx_full;
   wire [NUM_CH-1:0]       tx_empty;
   wire [WORD_W-1:0]       rx_word [NUM_CH];
   wire [NUM_CH-1:0]       rx_rd;
   wire [NUM_CH-1:0]       tx_wr;
   wire [WORD_W-1:0]       tx_word;
   wire                    cpl;
   wire ch_idx_t           cpl_ch;

   for (genvar c = 0; c < NUM_CPUS; c++)
   begin : g_cpu
      cpu_instr_decode u_dec (.clk(clk), .rst(rst), .i_cpu(i_cpu[c]), .o_op(cpu_op[c]));
   end

   chan_regs u_regs (
      .clk(clk), .rst(rst), .i_op(cpu_op), .i_cpl(cpl), .i_cpl_ch(cpl_ch),
      .o_active(active), .o_ca(ca), .o_cpu_ai(o_cpu_ai)
   );

   // Pair p is input 2p and output 2p+1
   for (genvar p = 0; p < NUM_CH/2; p++)
   begin : g_pair
      assign rx_full[2*p+1]  = 1'b0;
      assign rx_word[2*p+1]  = '0;
      assign tx_empty[2*p]   = 1'b0;

      chan_rx u_rx (
         .clk(clk), .rst(rst), .i_data(i_in_data[p]), .i_vld(i_in_vld[p]),
         .o_rdy(o_in_rdy[p]), .i_rd(rx_rd[2*p]), .o_full(rx_full[2*p]),
         .o_word(rx_word[2*p])
      );

      chan_tx u_tx (
         .clk(clk), .rst(rst), .i_wr(tx_wr[2*p+1]), .i_word(tx_word),
         .o_empty(tx_empty[2*p+1]), .o_data(o_out_data[p]), .o_vld(o_out_vld[p]),
         .i_rdy(i_out_rdy[p])
      );
   end

   mem_engine u_eng (
      .clk(clk), .rst(rst), .i_active(active), .i_ca(ca),
      .i_rx_full(rx_full), .i_rx_word(rx_word), .i_tx_empty(tx_empty),
      .o_rx_rd(rx_rd), .o_tx_wr(tx_wr), .o_tx_word(tx_word),
      .o_mem(o_mem), .i_mem_ack(i_mem_ack), .i_mem_rdata(i_mem_rdata),
      .o_cpl(cpl), .o_cpl_ch(cpl_ch)
   );

endmodule

`default_nettype wire

/* io_dma_asserts.sv */
// Memory and channel handshake checks
`timescale 1ns/1ps
`default_nettype none

module io_dma_asserts (
   input wire                          clk,
   input wire                          rst,
   input wire dma_pkg::mem_req_t       i_mem,
   input wire                          i_mem_ack,
   input wire [dma_pkg::HALF_W-1:0]    i_in_data [dma_pkg::NUM_CH/2],
   input wire [dma_pkg::NUM_CH/2-1:0]  i_in_vld,
   input wire [dma_pkg::NUM_CH/2-1:0]  i_in_rdy,
   input wire [dma_pkg::HALF_W-1:0]    i_out_data [dma_pkg::NUM_CH/2],
   input wire [dma_pkg::NUM_CH/2-1:0]  i_out_vld,
   input wire [dma_pkg::NUM_CH/2-1:0]  i_out_rdy
);
   import dma_pkg::*;

   int err_cnt;

   initial
      err_cnt = 0;

   // Request and its fields frozen until ack
   mem_hold: assert property (@(posedge clk) disable iff (rst)
      i_mem.req && !i_mem_ack |=> i_mem.req && $stable(i_mem))
      else
      begin
         $error("memory request dropped or changed before ack");
         err_cnt = err_cnt + 1;
      end

   for (genvar p = 0; p < NUM_CH/2; p++)
   begin : g_ch
      out_hold: assert property (@(posedge clk) disable iff (rst)
         i_out_vld[p] && !i_out_rdy[p] |=> i_out_vld[p] && $stable(i_out_data[p]))
         else
         begin
            $error("output channel valid or data changed before ready");
            err_cnt = err_cnt + 1;
         end

      in_hold: assert property (@(posedge clk) disable iff (rst)
         i_in_vld[p] && !i_in_rdy[p] |=> i_in_vld[p] && $stable(i_in_data[p]))
         else
         begin
            $error("input channel valid or data changed before ready");
            err_cnt = err_cnt + 1;
         end
   end

endmodule

bind io_dma_top io_dma_asserts u_asserts (
   .clk(clk), .rst(rst), .i_mem(o_mem), .i_mem_ack(i_mem_ack),
   .i_in_data(i_in_data), .i_in_vld(i_in_vld), .i_in_rdy(o_in_rdy),
   .i_out_data(o_out_data), .i_out_vld(o_out_vld), .i_out_rdy(i_out_rdy)
);

`default_nettype wire

/* tb_clkgen.sv */
// Testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
   output logic o_clk,
   output logic o_rst
);

   initial
   begin
      o_clk = 1'b0;
      forever
         #4 o_clk = ~o_clk;   // 8 ns period
   end

   // Reset held for 8 rising edges
   initial
   begin
      o_rst = 1'b1;
      repeat (8)
         @(posedge o_clk);
      #1 o_rst = 1'b0;
   end

endmodule

`default_nettype wire

/* tb_io_dma.sv */
// I/O DMA directed testbench
`timescale 1ns/1ps
`default_nettype none

module tb_io_dma;
   import dma_pkg::*;

   logic                clk;
   logic                rst;
   cpu_req_t            cpu_req [NUM_CPUS];
   logic [A_W-1:0]      cpu_ai [NUM_CPUS];
   logic [HALF_W-1:0]   in_data [NUM_CH/2];
   logic [NUM_CH/2-1:0] in_vld;
   logic [NUM_CH/2-1:0] in_rdy;
   logic [HALF_W-1:0]   out_data [NUM_CH/2];
   logic [NUM_CH/2-1:0] out_vld;
   logic [NUM_CH/2-1:0] out_rdy;
   logic [NUM_CH/2-1:0] rand_rdy;
   mem_req_t            mem_bus;
   logic                mem_ack;
   logic [WORD_W-1:0]   mem_rdata;

   logic [WORD_W-1:0]   mem [int];            // Sparse memory model
   logic [ADDR_W-1:0]   wr_q [$];             // Write addresses in order
   logic [HALF_W-1:0]   out_q [NUM_CH/2][$];  // Halfwords seen per output pair
   int                  delay;
   logic                done;
   int                  errors;
   int                  tests;
   int                  failed_tests;
   int                  test_err0;
   string               cur_test;

   tb_clkgen u_clkgen (.o_clk(clk), .o_rst(rst));

   io_dma_top i_dut (
      .clk(clk), .rst(rst), .i_cpu(cpu_req), .o_cpu_ai(cpu_ai),
      .i_in_data(in_data), .i_in_vld(in_vld), .o_in_rdy(in_rdy),
      .o_out_data(out_data), .o_out_vld(out_vld), .i_out_rdy(out_rdy),
      .o_mem(mem_bus), .i_mem_ack(mem_ack), .i_mem_rdata(mem_rdata)
   );

   ////////////////////
   // Memory model
   ////////////////////
   // Unwritten words carry a pattern of their full address
   function automatic logic [WORD_W-1:0] read_word(input int a);
      return mem.exists(a) ? mem[a] : {a[21:0] ^ 22'h2aaaaa, 20'h0, a[21:0]};
   endfunction

   // Handshake seen mid-cycle completes on the next edge
   always @(negedge clk)
   begin
      if (!rst && mem_bus.req && mem_ack)
      begin
         if (mem_bus.wr)
         begin
            mem[int'(mem_bus.addr)] = mem_bus.data;
            wr_q.push_back(mem_bus.addr);
         end
         done = 1'b1;
      end
   end

   always @(posedge clk)
   begin
      #1;
      mem_ack = 1'b0;
      if (done || !mem_bus.req)
         delay = -1;
      done = 1'b0;
      if (mem_bus.req)
      begin
         if (delay < 0)
            delay = $urandom_range(0, 3);   // New request
         if (delay == 0)
         begin
            mem_ack   = 1'b1;
            mem_rdata = read_word(int'(mem_bus.addr));
         end
         else
            delay = delay - 1;
      end
   end

   ////////////////////
   // Output sinks
   ////////////////////
   always @(negedge clk)
      for (int p = 0; p < NUM_CH/2; p++)
         if (!rst && out_vld[p] && out_rdy[p])
            out_q[p].push_back(out_data[p]);

   always @(posedge clk)
   begin
      #1;
      for (int p = 0; p < NUM_CH/2; p++)
         out_rdy[p] = rand_rdy[p] ? 1'($urandom_range(0, 1)) : 1'b1;
   end

   ////////////////////
   // Bookkeeping
   ////////////////////
   task automatic start_test(input string name);
      cur_test  = name;
      test_err0 = errors;
   endtask

   task automatic end_test();
      tests = tests + 1;
      if (errors > test_err0)
      begin
         failed_tests = failed_tests + 1;
         $display("Test %s: failed with %0d errors", cur_test, errors - test_err0);
      end
      else
         $display("Test %s: ok", cur_test);
   endtask

   task automatic check(input string what, input logic [63:0] exp, input logic [63:0] act);
      if (exp !== act)
      begin
         $display("Mismatch in %s (%s): expected %h, actual %h", cur_test, what, exp, act);
         errors = errors + 1;
      end
   endtask

   task automatic report_timeout(input string what);
      $display("Timeout in %s: %s never happened", cur_test, what);
      errors = errors + 1;
   endtask

   ////////////////////
   // CPU access
   ////////////////////
   function automatic cpu_req_t make_req(input logic [15:0] instr, input int aj,
                                         input logic [ADDR_W-1:0] val, input logic mon);
      cpu_req_t r;
      r          = '0;
      r.instr    = instr;
      r.mon_mode = mon;
      r.vld      = 1'b1;
      r.aj       = A_W'(aj);
      r.ak       = A_W'(val);
      return r;
   endfunction

   // Present both CPU words for one edge
   task automatic issue(input cpu_req_t r0, input cpu_req_t r1);
      cpu_req[0] = r0;
      cpu_req[1] = r1;
      @(posedge clk);
      #1;
      cpu_req[0].vld = 1'b0;
      cpu_req[1].vld = 1'b0;
   endtask

   task automatic write_reg(input int cpu, input logic [9:0] op, input int ch,
                            input logic [ADDR_W-1:0] val);
      cpu_req_t r;
      r = make_req({op, 6'd0}, CH_SEL_BASE + ch, val, 1'b1);
      if (cpu == 0)
         issue(r, '0);
      else
         issue('0, r);
   endtask

   // Result lands one edge after the instruction is flopped
   task automatic read_ai(input int cpu, input logic [5:0] jk, input int ch,
                          output logic [A_W-1:0] val);
      cpu_req_t r;
      r = make_req({OP_CHAN_READ, 3'd0, jk}, CH_SEL_BASE + ch, '0, 1'b1);
      if (cpu == 0)
         issue(r, '0);
      else
         issue('0, r);
      @(posedge clk);
      #1;
      val = cpu_ai[cpu];
   endtask

   ////////////////////
   // Channel helpers
   ////////////////////
   task automatic send_halves(input int p, input logic [HALF_W-1:0] h [$]);
      logic acc;
      int   n;
      for (int i = 0; i < h.size(); i++)
      begin
         in_data[p] = h[i];
         in_vld[p]  = 1'b1;
         acc        = 1'b0;
         n          = 0;
         while (!acc && n < 100)
         begin
            @(negedge clk);
            acc = in_rdy[p];   // Ready is stable mid-cycle
            @(posedge clk);
            #1;
            n = n + 1;
         end
         if (!acc)
         begin
            report_timeout("input channel ready");
            in_vld[p] = 1'b0;
            return;
         end
      end
      in_vld[p] = 1'b0;
   endtask

   task automatic wait_writes(input int cnt, input int limit);
      int n;
      n = 0;
      while (wr_q.size() < cnt && n < limit)
      begin
         @(posedge clk);
         #1;
         n = n + 1;
      end
      if (wr_q.size() < cnt)
         report_timeout("memory write");
   endtask

   task automatic wait_out(input int p, input int cnt, input int limit);
      int n;
      n = 0;
      while (out_q[p].size() < cnt && n < limit)
      begin
         @(posedge clk);
         #1;
         n = n + 1;
      end
      if (out_q[p].size() < cnt)
         report_timeout("output halfword");
   endtask

   // Halfwords must follow memory order, MS first
   task automatic check_out(input int p, input int base, input int nwords);
      logic [WORD_W-1:0] word;
      check("halfword count", nwords * HALVES_PER_WORD, out_q[p].size());
      for (int k = 0; k < nwords * HALVES_PER_WORD; k++)
         if (k < out_q[p].size())
         begin
            word = read_word(base + k / HALVES_PER_WORD);
            check("halfword", word[WORD_W-1-HALF_W*(k%HALVES_PER_WORD) -: HALF_W], out_q[p][k]);
         end
   endtask

   task automatic check_writes(input int base, input logic [HALF_W-1:0] h [$]);
      for (int w = 0; w < h.size() / HALVES_PER_WORD; w++)
         if (w < wr_q.size())
         begin
            check("write address", base + w, wr_q[w]);
            check("write data", {h[4*w], h[4*w+1], h[4*w+2], h[4*w+3]},
                  mem[int'(wr_q[w])]);
         end
   endtask

   ////////////////////
   // Directed tests
   ////////////////////
   task automatic test_reset();
      logic [A_W-1:0] v;
      start_test("after reset");
      check("mem req", 0, mem_bus.req);
      check("output valid", 0, out_vld);
      check("input ready", 2'b11, in_rdy);
      check("cpu1 result", 0, cpu_ai[1]);
      read_ai(0, 6'd0, 0, v);
      check("interrupt read", 0, v);
      end_test();
   endtask

   task automatic test_input();
      logic [HALF_W-1:0] h [$];
      logic [A_W-1:0]    v;
      start_test("input ch10");
      wr_q.delete();
      for (int i = 0; i < 12; i++)
         h.push_back(HALF_W'($urandom));
      write_reg(0, OP_WRITE_CL, 0, 22'h103);
      write_reg(0, OP_WRITE_CA, 0, 22'h100);
      send_halves(0, h);
      wait_writes(3, 200);
      check("write count", 3, wr_q.size());
      check_writes(32'h100, h);
      read_ai(0, 6'd1, 0, v);
      check("CA readback", 22'h103, v);
      read_ai(0, 6'd0, 0, v);
      check("ch10 interrupt", CH_SEL_BASE, v);
      end_test();
   endtask

   task automatic test_output();
      logic [A_W-1:0] v;
      start_test("output ch13");
      out_q[1].delete();
      for (int w = 0; w < 3; w++)
         mem[32'h200 + w] = {$urandom, $urandom};
      rand_rdy[1] = 1'b1;   // Random back-pressure
      write_reg(1, OP_WRITE_CL, 3, 22'h203);
      write_reg(1, OP_WRITE_CA, 3, 22'h200);
      wait_out(1, 12, 400);
      rand_rdy[1] = 1'b0;
      check_out(1, 32'h200, 3);
      check("valid after last", 0, out_vld[1]);
      read_ai(1, 6'd1, 3, v);
      check("CA readback", 22'h203, v);
      read_ai(1, 6'd0, 0, v);
      check("ch13 interrupt", CH_SEL_BASE + 3, v);
      end_test();
   endtask

   task automatic test_concurrent();
      logic [HALF_W-1:0] h [$];
      start_test("concurrent ch12 ch11");
      wr_q.delete();
      out_q[0].delete();
      for (int w = 0; w < 2; w++)
         mem[32'h400 + w] = {$urandom, $urandom};
      for (int i = 0; i < 8; i++)
         h.push_back(HALF_W'($urandom));
      rand_rdy[0] = 1'b1;
      write_reg(0, OP_WRITE_CL, 1, 22'h402);
      write_reg(0, OP_WRITE_CA, 1, 22'h400);
      write_reg(1, OP_WRITE_CL, 2, 22'h302);
      write_reg(1, OP_WRITE_CA, 2, 22'h300);
      send_halves(1, h);
      wait_writes(2, 300);
      wait_out(0, 8, 300);
      rand_rdy[0] = 1'b0;
      check("write count", 2, wr_q.size());
      check_writes(32'h300, h);
      check_out(0, 32'h400, 2);
      end_test();
   endtask

   // Pending after the concurrent test are ch11 and ch12
   task automatic test_interrupts();
      logic [A_W-1:0] v;
      start_test("interrupts");
      read_ai(0, 6'd0, 0, v);
      check("first read", CH_SEL_BASE + 1, v);
      read_ai(1, 6'd0, 0, v);
      check("second read", CH_SEL_BASE + 2, v);
      read_ai(0, 6'd0, 0, v);
      check("third read", 0, v);
      end_test();
   endtask

   task automatic test_priority();
      logic [HALF_W-1:0] h [$];
      logic [A_W-1:0]    v;
      start_test("cpu priority");
      wr_q.delete();
      for (int i = 0; i < 4; i++)
         h.push_back(HALF_W'($urandom));
      // One-word limit from CPU0, five-word limit from CPU1
      issue(make_req({OP_WRITE_CL, 6'd0}, CH_SEL_BASE, 22'h501, 1'b1),
            make_req({OP_WRITE_CL, 6'd0}, CH_SEL_BASE, 22'h505, 1'b1));
      write_reg(0, OP_WRITE_CA, 0, 22'h500);
      send_halves(0, h);
      wait_writes(1, 200);
      check_writes(32'h500, h);
      read_ai(0, 6'd0, 0, v);
      check("limit from CPU0", CH_SEL_BASE, v);
      issue('0, make_req({OP_WRITE_CA, 6'd0}, CH_SEL_BASE, 22'h777, 1'b0));
      read_ai(0, 6'd1, 0, v);
      check("CA after user mode write", 22'h501, v);
      end_test();
   endtask

   initial
   begin
      int n;
      void'($urandom(32'haa49));
      cpu_req[0] = '0;
      cpu_req[1] = '0;
      in_data[0] = '0;
      in_data[1] = '0;
      in_vld     = '0;
      out_rdy    = '1;
      rand_rdy   = '0;
      mem_ack    = 1'b0;
      mem_rdata  = '0;
      delay      = -1;
      done       = 1'b0;
      errors     = 0;
      tests      = 0;
      failed_tests = 0;
      n = 0;
      // Reset is known high from the first edge
      @(posedge clk);
      while (rst && n < 100)
      begin
         @(posedge clk);
         n = n + 1;
      end
      if (rst)
         report_timeout("reset release");
      @(posedge clk);
      #1;

      test_reset();
      test_input();
      test_output();
      test_concurrent();
      test_interrupts();
      test_priority();

      if (i_dut.u_asserts.err_cnt != 0)
      begin
         $display("Assertion failures: %0d", i_dut.u_asserts.err_cnt);
         errors = errors + 1;
      end
      $display("Summary: %0d tests, %0d failed, %0d errors", tests, failed_tests, errors);
      if (errors == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

/* files.f */
dma_pkg.sv
cpu_instr_decode.sv
chan_regs.sv
chan_rx.sv
chan_tx.sv
rr_arbiter.sv
mem_engine.sv
io_dma_top.sv
io_dma_asserts.sv
tb_clkgen.sv
tb_io_dma.sv

/* Makefile */
# Verilator build and run for the I/O DMA testbench

VERILATOR ?= verilator
TOP       ?= tb_io_dma
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the simulation and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then echo "Simulation reported errors"; exit 1; fi
	@if ! grep -q "ALL TESTS PASSED" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
